//--- vec_pkg.sv
package vec_pkg;

    // the register-file address width is sized so a vector length fits the counters
    localparam int RF_AW = 5;
    localparam int DW = 32; // element width
    localparam int MEM_AW = 8; // 256 words of data memory

    // one opcode names the instruction in flight
    typedef enum logic [2:0] {
        OP_NONE      = 3'd0,
        OP_VLE32     = 3'd1, // memory to vector registers
        OP_VSE32     = 3'd2, // vector registers to memory
        OP_VMACC     = 3'd3, // vw[i] += vr1 * vr2[i]
        OP_STREAMOUT = 3'd4  // vr1[i] + vr2[i] out on the stream strobe
    } vec_op_e;

    // the sequencer either waits for start or steps the element counters
    typedef enum logic {
        ST_IDLE  = 1'b0,
        ST_COUNT = 1'b1
    } seq_state_e;

endpackage

//--- vec_addr_seq.sv
`timescale 1ns/1ns

module vec_addr_seq #(
    parameter int RF_AW = vec_pkg::RF_AW
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,     // one-cycle pulse that also loads vlen
    input  vec_pkg::vec_op_e op,
    input  logic [RF_AW-1:0] vlen,
    input  logic [RF_AW-1:0] vr1_base,
    input  logic [RF_AW-1:0] vr2_base,
    input  logic [RF_AW-1:0] vw_base,
    input  logic             stall_rd,  // memory taken by the host this cycle
    input  logic             stall_wr,  // no result ready to write back
    output logic [RF_AW-1:0] vr1_addr,
    output logic [RF_AW-1:0] vr2_addr,
    output logic [RF_AW-1:0] vw_addr,
    output logic [RF_AW-1:0] rd_idx,
    output logic             rd_step,   // an element is read in this cycle
    output logic             done       // one-cycle pulse at the final event
);
    import vec_pkg::*;

    seq_state_e       state;
    seq_state_e       state_nx;
    logic [RF_AW-1:0] last_q;  // vlen minus one, latched at start
    logic [RF_AW-1:0] rd_cnt;
    logic [RF_AW-1:0] wr_cnt;
    logic             rd_fin;  // all elements have been read
    logic             wr_side;
    logic             rd_last;
    logic             wr_step;
    logic             wr_last;

    // the write side only counts for ops that put results into the register file
    assign wr_side = (op == OP_VLE32) || (op == OP_VMACC);

    assign rd_step = (state == ST_COUNT) && !rd_fin && !stall_rd;
    assign rd_last = rd_step && (rd_cnt == last_q);
    assign wr_step = (state == ST_COUNT) && wr_side && !stall_wr;
    assign wr_last = wr_step && (wr_cnt == last_q);

    // loads and vmacc finish on their last write, the others on their last read
    assign done = wr_side ? wr_last : rd_last;

    always_comb begin
        state_nx = state;
        case (state)
            ST_IDLE:  if (start) state_nx = ST_COUNT;
            ST_COUNT: if (done) state_nx = ST_IDLE;
            default:  state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_IDLE;
            last_q <= '0;
            rd_cnt <= '0;
            wr_cnt <= '0;
            rd_fin <= 1'b0;
        end else begin
            state <= state_nx;
            if (start) begin
                last_q <= vlen - 1'b1;
                rd_cnt <= '0;
                wr_cnt <= '0;
                rd_fin <= 1'b0;
            end else begin
                if (rd_last) rd_fin <= 1'b1; // read index parks on the last element
                else if (rd_step) rd_cnt <= rd_cnt + 1'b1;
                if (wr_step && !wr_last) wr_cnt <= wr_cnt + 1'b1; // held while stall_wr is high
            end
        end
    end

    // vmacc keeps the scalar operand register in place
    assign vr1_addr = (op == OP_VMACC) ? vr1_base : vr1_base + rd_cnt;
    assign vr2_addr = vr2_base + rd_cnt;
    assign vw_addr  = vw_base + wr_cnt; // read and written at the same index
    assign rd_idx   = rd_cnt;

endmodule

//--- vec_regfile.sv
`timescale 1ns/1ns

module vec_regfile #(
    parameter int RF_AW = vec_pkg::RF_AW,
    parameter int DW    = vec_pkg::DW
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [RF_AW-1:0] vr1_addr,
    input  logic [RF_AW-1:0] vr2_addr,
    input  logic [RF_AW-1:0] vw_addr,
    input  logic             wb_we,
    input  logic [DW-1:0]    wb_data,
    output logic [DW-1:0]    vr1_data,
    output logic [DW-1:0]    vr2_data,
    output logic [DW-1:0]    vw_data
);

    logic [DW-1:0] regs [2**RF_AW]; // one element per entry

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 2**RF_AW; i++) regs[i] <= '0;
        end else if (wb_we) begin
            regs[vw_addr] <= wb_data; // write port shares the vw address
        end
    end

    // asynchronous reads so the lane sees an element in its read cycle
    assign vr1_data = regs[vr1_addr];
    assign vr2_data = regs[vr2_addr];
    assign vw_data  = regs[vw_addr]; // old value for the vmacc accumulate

endmodule

//--- vec_lane.sv
`timescale 1ns/1ns

module vec_lane #(
    parameter int DW = vec_pkg::DW
) (
    input  logic             clk,
    input  logic             rst,
    input  vec_pkg::vec_op_e op,
    input  logic             rd_step,
    input  logic [DW-1:0]    vr1_data,
    input  logic [DW-1:0]    vr2_data,
    input  logic [DW-1:0]    vw_data,
    input  logic [DW-1:0]    eng_rdata,   // memory word for vle32 one cycle after the read
    output logic             wb_we,
    output logic [DW-1:0]    wb_data,
    output logic             stall_wr,
    output logic [DW-1:0]    st_data,
    output logic [DW-1:0]    stream_data,
    output logic             stream_valid
);
    import vec_pkg::*;

    logic          wr_op;
    logic          res_valid; // a result for the register file is ready
    logic [DW-1:0] prod_q;    // low DW bits of vr1 * vr2[i]
    logic [DW-1:0] sum_q;     // stream element

    assign wr_op = (op == OP_VLE32) || (op == OP_VMACC);

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid    <= 1'b0;
            stream_valid <= 1'b0;
        end else begin
            res_valid    <= rd_step && wr_op;
            stream_valid <= rd_step && (op == OP_STREAMOUT);
        end
    end

    always_ff @(posedge clk) begin
        prod_q <= vr1_data * vr2_data;
        sum_q  <= vr1_data + vr2_data;
    end

    // the accumulator is read at the write index in the write-back cycle itself,
    // so vw[i] is added to the registered product right before it is overwritten
    assign wb_we    = res_valid;
    assign wb_data  = (op == OP_VMACC) ? vw_data + prod_q : eng_rdata;
    assign stall_wr = wr_op && !res_valid; // bubble while the pipeline is empty

    assign st_data     = vr2_data; // vse32 stores the vr2 range
    assign stream_data = sum_q;

endmodule

//--- dmem_arbiter.sv
`timescale 1ns/1ns

module dmem_arbiter #(
    parameter int MEM_AW = vec_pkg::MEM_AW,
    parameter int DW     = vec_pkg::DW
) (
    input  vec_pkg::vec_op_e          op,
    input  logic                      rd_step,
    input  logic [vec_pkg::RF_AW-1:0] rd_idx,
    input  logic [MEM_AW-1:0]         mem_base,
    input  logic [DW-1:0]             st_data,
    input  logic                      host_en,
    input  logic                      host_we,
    input  logic [MEM_AW-1:0]         host_addr,
    input  logic [DW-1:0]             host_wdata,
    input  logic [DW-1:0]             mem_rdata,
    output logic                      stall_rd,
    output logic                      mem_en,
    output logic                      mem_we,
    output logic [MEM_AW-1:0]         mem_addr,
    output logic [DW-1:0]             mem_wdata,
    output logic [DW-1:0]             eng_rdata,
    output logic [DW-1:0]             host_rdata
);
    import vec_pkg::*;

    logic mem_op; // the current instruction needs the memory port

    assign mem_op   = (op == OP_VLE32) || (op == OP_VSE32);
    assign stall_rd = host_en && mem_op; // host has fixed priority

    always_comb begin
        if (host_en) begin
            mem_en    = 1'b1;
            mem_we    = host_we;
            mem_addr  = host_addr;
            mem_wdata = host_wdata;
        end else begin
            mem_en    = rd_step && mem_op;
            mem_we    = rd_step && (op == OP_VSE32); // store lands in the read cycle
            mem_addr  = mem_base + MEM_AW'(rd_idx);
            mem_wdata = st_data;
        end
    end

    // one read bus goes back to both peers and each samples only after its own read
    assign eng_rdata  = mem_rdata;
    assign host_rdata = mem_rdata;

endmodule

//--- vec_dmem.sv
`timescale 1ns/1ns

module vec_dmem #(
    parameter int MEM_AW = vec_pkg::MEM_AW,
    parameter int DW     = vec_pkg::DW
) (
    input  logic              clk,
    input  logic              mem_en,
    input  logic              mem_we,
    input  logic [MEM_AW-1:0] mem_addr,
    input  logic [DW-1:0]     mem_wdata,
    output logic [DW-1:0]     mem_rdata
);

    logic [DW-1:0] ram [2**MEM_AW];

    always_ff @(posedge clk) begin
        if (mem_en) begin
            if (mem_we) ram[mem_addr] <= mem_wdata;
            else mem_rdata <= ram[mem_addr]; // read data shows up the next cycle
        end
    end

endmodule

//--- vec_top.sv
`timescale 1ns/1ns

module vec_top #(
    parameter int RF_AW  = vec_pkg::RF_AW,
    parameter int DW     = vec_pkg::DW,
    parameter int MEM_AW = vec_pkg::MEM_AW
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              start,
    input  vec_pkg::vec_op_e  op,
    input  logic [RF_AW-1:0]  vlen,
    input  logic [RF_AW-1:0]  vr1_base,
    input  logic [RF_AW-1:0]  vr2_base,
    input  logic [RF_AW-1:0]  vw_base,
    input  logic [MEM_AW-1:0] mem_base,
    input  logic              host_en,
    input  logic              host_we,
    input  logic [MEM_AW-1:0] host_addr,
    input  logic [DW-1:0]     host_wdata,
    output logic [DW-1:0]     host_rdata,
    output logic [DW-1:0]     stream_data,
    output logic              stream_valid,
    output logic              done
);

    logic [RF_AW-1:0]  vr1_addr;
    logic [RF_AW-1:0]  vr2_addr;
    logic [RF_AW-1:0]  vw_addr;
    logic [RF_AW-1:0]  rd_idx;
    logic              rd_step;
    logic              stall_rd;
    logic              stall_wr;
    logic [DW-1:0]     vr1_data;
    logic [DW-1:0]     vr2_data;
    logic [DW-1:0]     vw_data;
    logic              wb_we;
    logic [DW-1:0]     wb_data;
    logic [DW-1:0]     st_data;
    logic [DW-1:0]     eng_rdata;
    logic              mem_en;
    logic              mem_we;
    logic [MEM_AW-1:0] mem_addr;
    logic [DW-1:0]     mem_wdata;
    logic [DW-1:0]     mem_rdata;

    // element index sequencer
    vec_addr_seq #(.RF_AW(RF_AW)) u_seq (
        .clk(clk), .rst(rst), .start(start), .op(op), .vlen(vlen),
        .vr1_base(vr1_base), .vr2_base(vr2_base), .vw_base(vw_base),
        .stall_rd(stall_rd), .stall_wr(stall_wr),
        .vr1_addr(vr1_addr), .vr2_addr(vr2_addr), .vw_addr(vw_addr),
        .rd_idx(rd_idx), .rd_step(rd_step), .done(done)
    );

    vec_regfile #(.RF_AW(RF_AW), .DW(DW)) u_rf (
        .clk(clk), .rst(rst),
        .vr1_addr(vr1_addr), .vr2_addr(vr2_addr), .vw_addr(vw_addr),
        .wb_we(wb_we), .wb_data(wb_data),
        .vr1_data(vr1_data), .vr2_data(vr2_data), .vw_data(vw_data)
    );

    vec_lane #(.DW(DW)) u_lane (
        .clk(clk), .rst(rst), .op(op), .rd_step(rd_step),
        .vr1_data(vr1_data), .vr2_data(vr2_data), .vw_data(vw_data),
        .eng_rdata(eng_rdata), .wb_we(wb_we), .wb_data(wb_data),
        .stall_wr(stall_wr), .st_data(st_data),
        .stream_data(stream_data), .stream_valid(stream_valid)
    );

    // host and engine share the single memory port
    dmem_arbiter #(.MEM_AW(MEM_AW), .DW(DW)) u_arb (
        .op(op), .rd_step(rd_step), .rd_idx(rd_idx), .mem_base(mem_base),
        .st_data(st_data), .host_en(host_en), .host_we(host_we),
        .host_addr(host_addr), .host_wdata(host_wdata), .mem_rdata(mem_rdata),
        .stall_rd(stall_rd), .mem_en(mem_en), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .eng_rdata(eng_rdata), .host_rdata(host_rdata)
    );

    vec_dmem #(.MEM_AW(MEM_AW), .DW(DW)) u_mem (
        .clk(clk), .mem_en(mem_en), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

//--- tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 100 // ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk; // free running clock whose first rising edge comes at half a period

endmodule

//--- tb_checker.sv
`timescale 1ns/1ns

module tb_checker #(
    parameter int DW = vec_pkg::DW
) (
    input logic          clk,
    input logic          host_en,
    input logic          host_we,
    input logic [DW-1:0] host_rdata,
    input logic [DW-1:0] stream_data,
    input logic          stream_valid,
    input logic          done
);

    logic [DW-1:0] host_q [$];   // expected host read words in issue order
    logic [DW-1:0] stream_q [$]; // expected stream elements in index order
    logic          rd_pend = 1'b0; // a host read was issued in the previous cycle
    int            done_cnt = 0;
    int            test_errs = 0;
    int            err_total = 0;
    int            tests = 0;
    int            failed = 0;

    function automatic void expect_host(input logic [DW-1:0] word);
        host_q.push_back(word);
    endfunction

    function automatic void expect_stream(input logic [DW-1:0] word);
        stream_q.push_back(word);
    endfunction

    // a wrong value on a named signal is shown with both sides in hex
    function automatic void mismatch(input string sig, input logic [DW-1:0] want,
                                     input logic [DW-1:0] got);
        $display("FAIL %s exp=%h got=%h", sig, want, got);
        test_errs++;
        err_total++;
    endfunction

    function automatic void problem(input string msg);
        $display("%s", msg);
        test_errs++;
        err_total++;
    endfunction

    function automatic void end_test(input string name);
        tests++;
        if (test_errs == 0) begin
            $display("test %0d %s: PASS", tests, name);
        end else begin
            failed++;
            $display("test %0d %s: FAIL with %0d errors", tests, name, test_errs);
        end
        test_errs = 0;
    endfunction

    // an instruction gives exactly one done pulse and leaves no stream element behind
    function automatic void end_instr(input string name, input int dones_before);
        int pulses;
        pulses = done_cnt - dones_before;
        if (pulses != 1) problem($sformatf("%0d done pulses where exactly one was expected",
                                           pulses));
        if (stream_q.size() != 0) problem("stream ended before all elements came out");
        end_test(name);
    endfunction

    function automatic void report();
        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests, tests - failed, failed, err_total);
    endfunction

    // sampled mid-cycle where the DUT outputs have settled
    always @(negedge clk) begin
        logic [DW-1:0] want;
        if (rd_pend) begin // read data comes back one cycle after the host read
            if (host_q.size() == 0) begin
                problem("host read data came back with no value expected");
            end else begin
                want = host_q.pop_front();
                if (host_rdata !== want) mismatch("host_rdata", want, host_rdata);
            end
        end
        rd_pend = host_en && !host_we;
        if (stream_valid) begin
            if (stream_q.size() == 0) begin
                problem("stream strobe arrived with no element left to expect");
            end else begin
                want = stream_q.pop_front();
                if (stream_data !== want) mismatch("stream_data", want, stream_data);
            end
        end
        if (done) done_cnt++; // one pulse per instruction is expected
    end

endmodule

//--- tb_top.sv
`timescale 1ns/1ns

module tb_top;
    import vec_pkg::*;

    localparam int DRV = 10;       // drive delay in ns after the rising edge
    localparam int NCOL = 7;       // words per record in the vectors file
    localparam int MAX_REC = 64;
    localparam int STALL_MAX = 8;  // host steals allowed in one instruction
    localparam logic [MEM_AW-1:0] SCRATCH_ADDR = 8'hf0; // outside every tested range
    localparam logic [DW-1:0] SCRATCH_DATA = 32'h5c5a_7c11;

    logic              clk;
    logic              rst;
    logic              start;
    vec_op_e           op;
    logic [RF_AW-1:0]  vlen;
    logic [RF_AW-1:0]  vr1_base;
    logic [RF_AW-1:0]  vr2_base;
    logic [RF_AW-1:0]  vw_base;
    logic [MEM_AW-1:0] mem_base;
    logic              host_en;
    logic              host_we;
    logic [MEM_AW-1:0] host_addr;
    logic [DW-1:0]     host_wdata;
    logic [DW-1:0]     host_rdata;
    logic [DW-1:0]     stream_data;
    logic              stream_valid;
    logic              done;
    logic [31:0]       vec [MAX_REC*NCOL]; // records as read from the vectors file
    logic [31:0]       lfsr = 32'h64cc_0375;
    int                limit = 0;
    int                cycles = 0;

    tb_clock #(.PERIOD(100)) u_clk (.clk(clk));

    vec_top #(.RF_AW(RF_AW), .DW(DW), .MEM_AW(MEM_AW)) DUT (
        .clk(clk), .rst(rst), .start(start), .op(op), .vlen(vlen),
        .vr1_base(vr1_base), .vr2_base(vr2_base), .vw_base(vw_base), .mem_base(mem_base),
        .host_en(host_en), .host_we(host_we), .host_addr(host_addr),
        .host_wdata(host_wdata), .host_rdata(host_rdata),
        .stream_data(stream_data), .stream_valid(stream_valid), .done(done)
    );

    tb_checker #(.DW(DW)) u_chk (
        .clk(clk), .host_en(host_en), .host_we(host_we), .host_rdata(host_rdata),
        .stream_data(stream_data), .stream_valid(stream_valid), .done(done)
    );

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'h8020_0003 : 32'h0);
    endfunction

    function automatic logic take_bit();
        logic b;
        b = lfsr[0];
        lfsr = lfsr_next(lfsr); // one step for every bit used
        return b;
    endfunction

    task automatic host_write(input logic [MEM_AW-1:0] a, input logic [DW-1:0] d);
        host_en = 1'b1;
        host_we = 1'b1;
        host_addr = a;
        host_wdata = d;
        @(posedge clk);
        #DRV;
        host_en = 1'b0;
        host_we = 1'b0;
    endtask

    task automatic host_read(input logic [MEM_AW-1:0] a, input logic [DW-1:0] want);
        u_chk.expect_host(want);
        host_en = 1'b1;
        host_addr = a;
        @(posedge clk);
        #DRV;
        host_en = 1'b0;
        @(posedge clk); // the checker compares in the middle of this cycle
        #DRV;
        u_chk.end_test($sformatf("host read %02h", a));
    endtask

    task automatic run_instr(input vec_op_e o, input logic [31:0] n, input logic [31:0] b1,
                             input logic [31:0] b2, input logic [31:0] bw,
                             input logic [31:0] bm);
        int   dones;
        int   steals;
        logic seen;
        logic steal;
        dones = u_chk.done_cnt;
        steals = 0;
        seen = 1'b0;
        op = o; // held until done
        vlen = RF_AW'(n);
        vr1_base = RF_AW'(b1);
        vr2_base = RF_AW'(b2);
        vw_base = RF_AW'(bw);
        mem_base = MEM_AW'(bm);
        start = 1'b1;
        @(posedge clk);
        #DRV;
        start = 1'b0;
        while (!seen) begin
            // taking two bits per cycle lets the host steal about one cycle in four
            steal = take_bit() & take_bit();
            if (steal && (o == OP_VLE32 || o == OP_VSE32) && steals < STALL_MAX) begin
                steals++;
                host_en = 1'b1;
                host_addr = SCRATCH_ADDR;
                u_chk.expect_host(SCRATCH_DATA);
            end else begin
                host_en = 1'b0;
            end
            @(negedge clk);
            seen = done;
            @(posedge clk);
            #DRV;
        end
        host_en = 1'b0;
        op = OP_NONE;
        repeat (2) begin // lets the last stream strobe and scratch read drain
            @(posedge clk);
            #DRV;
        end
        u_chk.end_instr(o.name(), dones);
    endtask

    initial begin
        int          nrec;
        int          max_len;
        int          r;
        int          b;
        logic [31:0] kind;
        rst = 1'b1;
        start = 1'b0;
        op = OP_NONE;
        vlen = '0;
        vr1_base = '0;
        vr2_base = '0;
        vw_base = '0;
        mem_base = '0;
        host_en = 1'b0;
        host_we = 1'b0;
        host_addr = '0;
        host_wdata = '0;
        $readmemh("vec_vectors.txt", vec);
        nrec = 0;
        max_len = 0;
        while (nrec < MAX_REC && vec[nrec*NCOL] != 32'd0) begin
            if (vec[nrec*NCOL] == 32'd3 && vec[nrec*NCOL+2] > max_len) max_len = vec[nrec*NCOL+2];
            nrec++;
        end
        limit = (nrec + 1) * (max_len + STALL_MAX + 8); // end record counted too
        repeat (10) @(posedge clk);
        #DRV;
        rst = 1'b0;
        host_write(SCRATCH_ADDR, SCRATCH_DATA); // known word for the stolen reads
        for (r = 0; r < nrec; r++) begin
            b = r * NCOL;
            kind = vec[b];
            case (kind)
                32'd1: host_write(MEM_AW'(vec[b+1]), vec[b+2]);
                32'd2: host_read(MEM_AW'(vec[b+1]), vec[b+2]);
                32'd3: run_instr(vec_op_e'(vec[b+1][2:0]), vec[b+2], vec[b+3], vec[b+4],
                                 vec[b+5], vec[b+6]);
                32'd4: u_chk.expect_stream(vec[b+1]);
                default: u_chk.problem($sformatf("unknown command %0d in record %0d", kind, r));
            endcase
        end
        @(posedge clk);
        #DRV;
        u_chk.report();
        if (u_chk.err_total == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // the watchdog limit is known once the vectors have been scanned at time zero
    initial begin
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: the vectors did not finish within %0d cycles", limit);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

//--- vec_vectors.txt
// cmd a b c d e f in hex. 1 host write a=addr b=data, 2 host read a=addr b=expected,
// 3 instruction a=op b=vlen c=vr1 d=vr2 e=vw f=mem_base, 4 stream element a, 0 end
1 10 00001234 0 0 0 0
2 10 00001234 0 0 0 0
1 20 00000003 0 0 0 0
1 21 00000010 0 0 0 0
1 22 0000abcd 0 0 0 0
1 23 12345678 0 0 0 0
1 24 80000001 0 0 0 0
1 25 ffffffff 0 0 0 0
1 26 00ff00ff 0 0 0 0
1 27 7ffffffe 0 0 0 0
3 1 8 00 00 08 20
4 00000003 0 0 0 0 0
4 00000010 0 0 0 0 0
4 0000abcd 0 0 0 0 0
4 12345678 0 0 0 0 0
4 80000001 0 0 0 0 0
4 ffffffff 0 0 0 0 0
4 00ff00ff 0 0 0 0 0
4 7ffffffe 0 0 0 0 0
3 4 8 08 18 00 00
// two vmacc passes with scalar 3 leave six times each loaded word
3 3 8 08 08 10 00
3 3 8 08 08 10 00
3 2 8 00 10 00 40
2 40 00000012 0 0 0 0
2 41 00000060 0 0 0 0
2 42 000406ce 0 0 0 0
2 43 6d3a06d0 0 0 0 0
2 44 00000006 0 0 0 0
2 45 fffffffa 0 0 0 0
2 46 05fa05fa 0 0 0 0
2 47 fffffff4 0 0 0 0
0 0 0 0 0 0 0

//--- sim.f
vec_pkg.sv
vec_addr_seq.sv
vec_regfile.sv
vec_lane.sv
dmem_arbiter.sv
vec_dmem.sv
vec_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -f sim.f \
    && ./obj_dir/Vtb_top > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no result line found in sim.log"; exit 1; }
exit 0
